// ==== common/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  localparam int CMD_WIDTH        = 16;
  localparam int DATA_WIDTH       = 8;
  localparam int CLKS_PER_BIT     = 16;
  localparam int BIT_CNT_W        = $clog2(CLKS_PER_BIT);
  localparam int BIT_IDX_W        = $clog2(DATA_WIDTH);
  localparam int GAP_BITS         = 4;
  localparam int RSP_TIMEOUT_BITS = 64;

  localparam int GAP_CYCLES         = GAP_BITS * CLKS_PER_BIT;
  localparam int GAP_CNT_W          = $clog2(GAP_CYCLES);
  localparam int RSP_TIMEOUT_CYCLES = RSP_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int TMO_CNT_W          = $clog2(RSP_TIMEOUT_CYCLES);

  // last count of a bit period and of a half period.
  localparam logic [BIT_CNT_W-1:0] BIT_LAST  = BIT_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_CNT_W-1:0] HALF_LAST = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [BIT_IDX_W-1:0] IDX_LAST  = BIT_IDX_W'(DATA_WIDTH - 1);

  // the gap ends early by the two cycles it takes to launch the next frame.
  localparam logic [GAP_CNT_W-1:0] GAP_LAST = GAP_CNT_W'(GAP_CYCLES - 3);
  localparam logic [TMO_CNT_W-1:0] TMO_LAST = TMO_CNT_W'(RSP_TIMEOUT_CYCLES - 1);

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_WAIT_RSP,
    S_DONE
  } ctrl_state_e;

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

endpackage

// ==== uart/uart_tx.sv ====
module uart_tx import uart_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_start,
  input  logic [DATA_WIDTH-1:0] tx_byte,
  output logic                  tx,
  output logic                  tx_busy,
  output logic                  tx_done
);

  tx_state_e             state;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  parity_q;
  logic                  bit_end;

  assign bit_end = (bit_cnt == BIT_LAST);
  assign tx_busy = (state != TX_IDLE);
  assign tx_done = (state == TX_STOP) && bit_end;

  // byte shifts right once per data bit, so data_q[0] is always the current bit.
  always_ff @(posedge clk)
  begin
    if (state == TX_IDLE && tx_start)
    begin
      data_q   <= tx_byte;
      parity_q <= ~^tx_byte;
    end
    else if (state == TX_DATA && bit_end)
    begin
      data_q <= data_q >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (state == TX_IDLE)
    begin
      if (tx_start)
      begin
        state   <= TX_START;
        bit_cnt <= '0;
        tx      <= 1'b0;
      end
    end
    else if (!bit_end)
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
    else
    begin
      bit_cnt <= '0;
      case (state)
        TX_START:
        begin
          state   <= TX_DATA;
          bit_idx <= '0;
          tx      <= data_q[0];
        end
        TX_DATA:
        begin
          if (bit_idx == IDX_LAST)
          begin
            state <= TX_PARITY;
            tx    <= parity_q;
          end
          else
          begin
            bit_idx <= bit_idx + 1'b1;
            tx      <= data_q[1];
          end
        end
        TX_PARITY:
        begin
          state <= TX_STOP;
          tx    <= 1'b1;
        end
        default:
        begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== uart/uart_rx.sv ====
module uart_rx import uart_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx_en,
  input  logic                  rx,
  output logic                  rx_started,
  output logic                  rx_valid,
  output logic [DATA_WIDTH-1:0] rx_byte,
  output logic                  rx_err
);

  rx_state_e             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  logic [DATA_WIDTH-1:0] shreg;
  logic                  par_bit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // data and parity are sampled at mid-bit.
  always_ff @(posedge clk)
  begin
    if (state == RX_DATA && bit_cnt == BIT_LAST)
    begin
      shreg <= {rx_sync, shreg[DATA_WIDTH-1:1]};
    end
    if (state == RX_PARITY && bit_cnt == BIT_LAST)
    begin
      par_bit <= rx_sync;
    end
    if (state == RX_STOP && bit_cnt == BIT_LAST)
    begin
      rx_byte <= shreg;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= RX_IDLE;
      bit_cnt    <= '0;
      bit_idx    <= '0;
      rx_started <= 1'b0;
      rx_valid   <= 1'b0;
      rx_err     <= 1'b0;
    end
    else
    begin
      rx_started <= 1'b0;
      rx_valid   <= 1'b0;
      if (!rx_en)
      begin
        state <= RX_IDLE;
      end
      else
      begin
        case (state)
          RX_IDLE:
          begin
            if (rx_prev && !rx_sync)
            begin
              state   <= RX_START;
              bit_cnt <= '0;
            end
          end
          RX_START:
          begin
            if (bit_cnt == HALF_LAST)
            begin
              bit_cnt <= '0;
              bit_idx <= '0;
              // a glitch that is gone by mid-bit is not a start.
              if (!rx_sync)
              begin
                state      <= RX_DATA;
                rx_started <= 1'b1;
              end
              else
              begin
                state <= RX_IDLE;
              end
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          default:
          begin
            if (bit_cnt != BIT_LAST)
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
            else
            begin
              bit_cnt <= '0;
              case (state)
                RX_DATA:
                begin
                  if (bit_idx == IDX_LAST)
                  begin
                    state <= RX_PARITY;
                  end
                  bit_idx <= bit_idx + 1'b1;
                end
                RX_PARITY:
                begin
                  state <= RX_STOP;
                end
                default:
                begin
                  state    <= RX_IDLE;
                  rx_valid <= 1'b1;
                  // needs odd parity over data and parity bit and a high stop bit.
                  rx_err   <= ~(^{shreg, par_bit}) | ~rx_sync;
                end
              endcase
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== hdl/uart_cmd_ctrl.sv ====
module uart_cmd_ctrl import uart_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  tx_start,
  output logic [DATA_WIDTH-1:0] tx_byte,
  input  logic                  tx_busy,
  input  logic                  tx_done,
  output logic                  rx_en,
  input  logic                  rx_started,
  input  logic                  rx_valid,
  input  logic [DATA_WIDTH-1:0] rx_byte,
  input  logic                  rx_err,
  output logic [DATA_WIDTH-1:0] read_data,
  output logic                  read_rdy,
  output logic                  read_err
);

  ctrl_state_e          state;
  logic [CMD_WIDTH-1:0] cmd_q;
  cmd_op_e              op;
  logic                 issued;
  logic                 got_start;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic [TMO_CNT_W-1:0] tmo_cnt;
  logic                 rsp_timeout;

  assign op      = cmd_op_e'(cmd_q[CMD_WIDTH-1]);
  assign cmd_rdy = (state == S_IDLE);
  assign rx_en   = (state == S_WAIT_RSP);
  assign tx_byte = (state == S_SEND_HI) ? cmd_q[CMD_WIDTH-1 -: DATA_WIDTH]
                                        : cmd_q[DATA_WIDTH-1:0];

  // timeout only counts until the remote side has begun its answer.
  assign rsp_timeout = (state == S_WAIT_RSP) && !got_start && !rx_started &&
                       (tmo_cnt == TMO_LAST);

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_q <= cmd_in;
    end
    if (state == S_WAIT_RSP && rx_valid)
    begin
      read_data <= rx_byte;
    end
    else if (rsp_timeout)
    begin
      read_data <= '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      tx_start  <= 1'b0;
      issued    <= 1'b0;
      got_start <= 1'b0;
      gap_cnt   <= '0;
      tmo_cnt   <= '0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (cmd_vld)
          begin
            state <= S_SEND_HI;
          end
        end
        S_SEND_HI, S_SEND_LO:
        begin
          // one launch per frame, then wait for the stop bit to finish.
          if (!issued && !tx_busy)
          begin
            tx_start <= 1'b1;
            issued   <= 1'b1;
          end
          if (tx_done)
          begin
            issued <= 1'b0;
            if (state == S_SEND_HI)
            begin
              state   <= S_GAP;
              gap_cnt <= '0;
            end
            else if (op == OP_WRITE)
            begin
              state <= S_DONE;
            end
            else
            begin
              state     <= S_WAIT_RSP;
              tmo_cnt   <= '0;
              got_start <= 1'b0;
            end
          end
        end
        S_GAP:
        begin
          if (gap_cnt == GAP_LAST)
          begin
            state <= S_SEND_LO;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        S_WAIT_RSP:
        begin
          if (rx_valid)
          begin
            state    <= S_DONE;
            read_rdy <= 1'b1;
            read_err <= rx_err;
          end
          else if (rsp_timeout)
          begin
            state    <= S_DONE;
            read_rdy <= 1'b1;
            read_err <= 1'b1;
          end
          else if (rx_started)
          begin
            got_start <= 1'b1;
          end
          else if (!got_start)
          begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hdl/uart_cmd_top.sv ====
module uart_cmd_top import uart_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  rx,
  output logic                  tx,
  output logic [DATA_WIDTH-1:0] read_data,
  output logic                  read_rdy,
  output logic                  read_err
);

  logic                  tx_start;
  logic [DATA_WIDTH-1:0] tx_byte;
  logic                  tx_busy;
  logic                  tx_done;
  logic                  rx_en;
  logic                  rx_started;
  logic                  rx_valid;
  logic [DATA_WIDTH-1:0] rx_byte;
  logic                  rx_err;

  uart_cmd_ctrl ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .tx_done    (tx_done),
    .rx_en      (rx_en),
    .rx_started (rx_started),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .rx_err     (rx_err),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .read_err   (read_err)
  );

  uart_tx tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx rx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_en      (rx_en),
    .rx         (rx),
    .rx_started (rx_started),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .rx_err     (rx_err)
  );

endmodule

// ==== sim/uart_cmd_sva.sv ====
module uart_cmd_sva (
  input logic clk,
  input logic rst_n,
  input logic cmd_rdy,
  input logic tx_start,
  input logic tx_busy,
  input logic read_rdy
);

  property p_read_rdy_single;
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy;
  endproperty

  // a launch into a busy transmitter would be lost.
  property p_start_when_idle;
    @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy;
  endproperty

  // a command stays in flight while its frame is launched or sent.
  property p_rdy_not_sending;
    @(posedge clk) disable iff (!rst_n) (tx_start || tx_busy) |-> !cmd_rdy;
  endproperty

  a_read_rdy_single: assert property (p_read_rdy_single)
    else $error("read_rdy high for more than one cycle");
  a_start_when_idle: assert property (p_start_when_idle)
    else $error("tx_start issued while tx_busy is high");
  a_rdy_not_sending: assert property (p_rdy_not_sending)
    else $error("cmd_rdy high while a frame is in progress");

endmodule

bind uart_cmd_ctrl uart_cmd_sva sva_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_rdy  (cmd_rdy),
  .tx_start (tx_start),
  .tx_busy  (tx_busy),
  .read_rdy (read_rdy)
);

// ==== sim/tb_uart_cmd.sv ====
module tb_uart_cmd import uart_cmd_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic [DATA_WIDTH-1:0] read_data;
  logic                  read_rdy;
  logic                  read_err;

  int          errors;
  int          tests;
  int          cycle = 0;
  int          rdy_count = 0;
  logic [15:0] lfsr;

  uart_cmd_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  // counts every read result strobe so writes can prove they produced none.
  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
    begin
      rdy_count <= rdy_count + 1;
    end
  end

  // feedback taps x^16 + x^14 + x^13 + x^11 with one step per bit taken.
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[14:0], fb};
    end
    return val;
  endfunction

  task automatic note_failure(input string what);
    $display("%0t: %s", $time, what);
    errors++;
  endtask

  task automatic check_byte(input string name, input logic [DATA_WIDTH-1:0] exp,
                            input logic [DATA_WIDTH-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %02h actual %02h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_op(input string name, input cmd_op_e exp, input cmd_op_e act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start_err);
    tests++;
    $display("test %s: %s", name, (errors == start_err) ? "ok" : "failed");
  endtask

  task automatic wait_cmd_rdy(input int limit);
    int n;
    n = 0;
    while (cmd_rdy !== 1'b1 && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy !== 1'b1)
    begin
      note_failure("cmd_rdy did not return high in time");
    end
  endtask

  task automatic pulse_cmd(input logic [CMD_WIDTH-1:0] cmd);
    @(posedge clk);
    #1;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  task automatic issue_cmd(input logic [CMD_WIDTH-1:0] cmd);
    wait_cmd_rdy(32 * CLKS_PER_BIT);
    pulse_cmd(cmd);
  endtask

  // samples tx at the middle of each bit as counted from the falling edge.
  task automatic capture_frame(output logic [DATA_WIDTH-1:0] data, output logic par,
                               output logic stop, output int fall_cycle);
    int n;
    data       = '0;
    par        = 1'b0;
    stop       = 1'b0;
    fall_cycle = 0;
    n          = 0;
    while (tx !== 1'b0 && n < 2 * (11 + GAP_BITS) * CLKS_PER_BIT)
    begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0)
    begin
      note_failure("no start bit seen on tx");
    end
    else
    begin
      fall_cycle = cycle;
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (tx !== 1'b0)
      begin
        note_failure("tx start bit did not last to mid-bit");
      end
      for (int i = 0; i < DATA_WIDTH; i++)
      begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      par = tx;
      repeat (CLKS_PER_BIT) @(negedge clk);
      stop = tx;
    end
  endtask

  task automatic expect_frame(input string name, input logic [DATA_WIDTH-1:0] exp,
                              output logic [DATA_WIDTH-1:0] data, output int fall_cycle);
    logic par;
    logic stop;
    capture_frame(data, par, stop, fall_cycle);
    check_byte(name, exp, data);
    // odd parity sets the bit when the byte holds an even count of ones.
    check_bit({name, " parity"}, ($countones(exp) % 2) == 0, par);
    check_bit({name, " stop"}, 1'b1, stop);
  endtask

  // returns once the stop bit is on the line so the result can be watched.
  task automatic send_frame(input logic [DATA_WIDTH-1:0] data, input logic bad_par);
    logic [DATA_WIDTH+2:0] bits;
    bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
    @(posedge clk);
    #1;
    rx = bits[0];
    for (int i = 1; i < DATA_WIDTH + 3; i++)
    begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
      rx = bits[i];
    end
  endtask

  task automatic wait_read(input int limit, output logic [DATA_WIDTH-1:0] data,
                           output logic err);
    int n;
    n    = 0;
    data = '0;
    err  = 1'b0;
    @(negedge clk);
    while (read_rdy !== 1'b1 && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (read_rdy !== 1'b1)
    begin
      note_failure("read_rdy did not pulse in time");
    end
    else
    begin
      data = read_data;
      err  = read_err;
    end
  endtask

  task automatic test_reset();
    int start_err;
    start_err = errors;
    @(negedge clk);
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    check_bit("tx", 1'b1, tx);
    check_bit("read_rdy", 1'b0, read_rdy);
    check_bit("read_err", 1'b0, read_err);
    finish_test("reset", start_err);
  endtask

  task automatic test_write(input int idx, input logic busy);
    logic [15:0]           rnd;
    logic [CMD_WIDTH-1:0]  cmd;
    logic [DATA_WIDTH-1:0] hi;
    logic [DATA_WIDTH-1:0] lo;
    int                    hi_fall;
    int                    lo_fall;
    int                    start_err;
    int                    base;
    start_err = errors;
    base      = rdy_count;
    rnd       = rand_bits(15);
    cmd       = {1'b1, rnd[14:0]};
    issue_cmd(cmd);
    if (busy)
    begin
      pulse_cmd(cmd ^ 16'h7fff);
    end
    expect_frame("tx high byte", cmd[CMD_WIDTH-1 -: DATA_WIDTH], hi, hi_fall);
    check_op("op", OP_WRITE, cmd_op_e'(hi[DATA_WIDTH-1]));
    if (busy)
    begin
      pulse_cmd(cmd ^ 16'h7fff);
    end
    expect_frame("tx low byte", cmd[DATA_WIDTH-1:0], lo, lo_fall);
    if (lo_fall - hi_fall < (11 + GAP_BITS) * CLKS_PER_BIT)
    begin
      note_failure($sformatf("frames only %0d cycles apart", lo_fall - hi_fall));
    end
    wait_cmd_rdy(4 * CLKS_PER_BIT);
    if (busy)
    begin
      // an accepted second command would start a frame within this window.
      for (int i = 0; i < 2 * (11 + GAP_BITS) * CLKS_PER_BIT; i++)
      begin
        @(negedge clk);
        if (tx !== 1'b1)
        begin
          note_failure("extra frame started after an ignored command");
          break;
        end
      end
    end
    if (rdy_count != base)
    begin
      note_failure("read_rdy pulsed during a write");
    end
    finish_test($sformatf("%s %0d", busy ? "busy" : "write", idx), start_err);
  endtask

  task automatic test_read(input string name, input logic bad_par, input logic silent);
    logic [15:0]           rnd;
    logic [CMD_WIDTH-1:0]  cmd;
    logic [DATA_WIDTH-1:0] rsp;
    logic [DATA_WIDTH-1:0] hi;
    logic [DATA_WIDTH-1:0] lo;
    logic [DATA_WIDTH-1:0] data;
    logic                  err;
    int                    hi_fall;
    int                    lo_fall;
    int                    start_err;
    start_err = errors;
    rnd       = rand_bits(15);
    cmd       = {1'b0, rnd[14:0]};
    rnd       = rand_bits(DATA_WIDTH);
    rsp       = rnd[DATA_WIDTH-1:0];
    issue_cmd(cmd);
    expect_frame("tx high byte", cmd[CMD_WIDTH-1 -: DATA_WIDTH], hi, hi_fall);
    check_op("op", OP_READ, cmd_op_e'(hi[DATA_WIDTH-1]));
    expect_frame("tx low byte", cmd[DATA_WIDTH-1:0], lo, lo_fall);
    if (silent)
    begin
      wait_read((RSP_TIMEOUT_BITS + 2) * CLKS_PER_BIT, data, err);
      check_byte("read_data", '0, data);
      check_bit("read_err", 1'b1, err);
    end
    else
    begin
      // let the bridge reach its response wait before the answer starts.
      repeat (CLKS_PER_BIT) @(posedge clk);
      send_frame(rsp, bad_par);
      wait_read(4 * CLKS_PER_BIT, data, err);
      if (!bad_par)
      begin
        check_byte("read_data", rsp, data);
      end
      check_bit("read_err", bad_par, err);
    end
    wait_cmd_rdy(4 * CLKS_PER_BIT);
    finish_test(name, start_err);
  endtask

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    errors  = 0;
    tests   = 0;
    lfsr    = 16'd50;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    for (int i = 0; i < 4; i++)
    begin
      test_write(i, 1'b0);
    end
    test_read("read 0", 1'b0, 1'b0);
    test_read("read 1", 1'b0, 1'b0);
    test_read("read bad parity", 1'b1, 1'b0);
    test_read("read timeout", 1'b0, 1'b1);
    test_write(0, 1'b1);
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
common/uart_cmd_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/uart_cmd_ctrl.sv
hdl/uart_cmd_top.sv
sim/uart_cmd_sva.sv
sim/tb_uart_cmd.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_uart_cmd -f tb.f -o tb_uart_cmd \
  && ./obj_dir/tb_uart_cmd | tee /dev/stderr | grep -q "^Finished with no errors$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
